//--- design/blend_pkg.sv
`default_nettype none

package blend_pkg;

	localparam int chan_w = 8;
	localparam int num_chan = 3;
	localparam int weight_w = chan_w + 1;
	localparam int prod_w = 2 * chan_w;

	// weight of a fully opaque overlay pixel.
	localparam logic [weight_w-1:0] full_weight = weight_w'(1 << chan_w);

	typedef struct packed {
		logic [chan_w-1:0] pix;
		logic              sof;
		logic              eol;
	} grey_beat_t;

	typedef struct packed {
		logic [num_chan-1:0][chan_w-1:0] rgb;
		logic [chan_w-1:0]               alpha;
		logic                            sof;
		logic                            eol;
	} ovl_beat_t;

	typedef struct packed {
		logic [num_chan-1:0][chan_w-1:0] rgb;
		logic                            sof;
		logic                            eol;
	} rgb_beat_t;

	typedef enum logic {
		mode_pass  = 1'b0,
		mode_blend = 1'b1
	} blend_mode_t;

	typedef enum logic {
		st_hunt   = 1'b0,
		st_locked = 1'b1
	} align_state_t;

	// 0..255 maps onto 0..256 so that 255 is fully opaque.
	function automatic logic [weight_w-1:0] alpha_weight(input logic [chan_w-1:0] alpha);
		return {1'b0, alpha} + weight_w'(alpha[chan_w-1]);
	endfunction

endpackage

`default_nettype wire

//--- design/stream_align.sv
`default_nettype none

module stream_align #(
	parameter type beat_t = logic
) (
	input  logic  clk,
	input  logic  resetn,
	input  logic  in_valid,
	output logic  in_ready,
	input  beat_t in_beat,
	output logic  out_valid,
	input  logic  out_ready,
	output beat_t out_beat
);
	import blend_pkg::*;

	align_state_t state;
	align_state_t state_next;

	logic  skid_valid;
	beat_t skid_beat;

	logic in_fire;
	logic keep;
	logic out_free;

	// ready comes straight from a flop.
	assign in_ready = ~skid_valid;
	assign in_fire  = in_valid && in_ready;

	// output register empty or draining this cycle.
	assign out_free = ~out_valid || out_ready;

	// beats before the first frame start are dropped.
	assign keep = in_fire && (state == st_locked || in_beat.sof);

	always_comb begin
		state_next = state;
		case (state)
			st_hunt: begin
				if (in_fire && in_beat.sof) begin
					state_next = st_locked;
				end
			end
			st_locked: begin
				state_next = st_locked; // held until reset.
			end
			default: begin
				state_next = st_hunt;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= st_hunt;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else if (out_free) begin
			out_valid  <= skid_valid || keep;
			skid_valid <= 1'b0; // skid drains first.
		end else if (keep) begin
			skid_valid <= 1'b1; // park beat while stalled.
		end
	end

	always_ff @(posedge clk) begin
		if (out_free) begin
			if (skid_valid) begin
				out_beat <= skid_beat;
			end else if (keep) begin
				out_beat <= in_beat;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!out_free && keep) begin
			skid_beat <= in_beat;
		end
	end

endmodule

`default_nettype wire

//--- design/alpha_blend.sv
`default_nettype none

module alpha_blend (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  ovl_enable,
	input  logic                  bg_valid,
	output logic                  bg_ready,
	input  blend_pkg::grey_beat_t bg_beat,
	input  logic                  ovl_valid,
	output logic                  ovl_ready,
	input  blend_pkg::ovl_beat_t  ovl_beat,
	output logic                  out_valid,
	input  logic                  out_ready,
	output blend_pkg::rgb_beat_t  out_beat
);
	import blend_pkg::*;

	typedef struct packed {
		logic [num_chan-1:0][prod_w-1:0] ovl_prod;
		logic [num_chan-1:0][prod_w-1:0] bg_prod;
		logic                            sof;
		logic                            eol;
	} prod_beat_t;

	blend_mode_t mode;
	blend_mode_t new_mode;
	blend_mode_t beat_mode;

	logic advance;
	logic join_fire;

	logic [weight_w-1:0]             weight;
	logic [num_chan-1:0][chan_w-1:0] ovl_rgb;

	prod_beat_t prod_d;
	prod_beat_t prod_q;
	logic       prod_valid;

	logic [num_chan-1:0][prod_w-1:0] sum;

	assign new_mode = ovl_enable ? mode_blend : mode_pass;

	// a frame start beat already runs in the newly sampled mode.
	assign beat_mode = bg_beat.sof ? new_mode : mode;

	// both stages move together.
	assign advance = ~out_valid || out_ready;

	assign bg_ready  = advance && (beat_mode == mode_pass || ovl_valid);
	assign ovl_ready = advance && bg_valid && beat_mode == mode_blend;
	assign join_fire = bg_valid && bg_ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			mode <= mode_pass;
		end else if (join_fire && bg_beat.sof) begin
			mode <= new_mode;
		end
	end

	// pass mode is a blend with zero weight.
	always_comb begin
		if (beat_mode == mode_blend) begin
			weight  = alpha_weight(ovl_beat.alpha);
			ovl_rgb = ovl_beat.rgb;
		end else begin
			weight  = '0;
			ovl_rgb = '0;
		end
	end

	always_comb begin
		prod_d.sof = bg_beat.sof;
		prod_d.eol = bg_beat.eol;
		for (int c = 0; c < num_chan; c++) begin
			prod_d.ovl_prod[c] = prod_w'(ovl_rgb[c] * weight);
			prod_d.bg_prod[c]  = prod_w'(bg_beat.pix * (full_weight - weight));
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			prod_valid <= 1'b0;
			out_valid  <= 1'b0;
		end else if (advance) begin
			prod_valid <= join_fire;
			out_valid  <= prod_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && join_fire) begin
			prod_q <= prod_d;
		end
	end

	always_comb begin
		for (int c = 0; c < num_chan; c++) begin
			sum[c] = prod_q.ovl_prod[c] + prod_q.bg_prod[c]; // never exceeds 255 * 256.
		end
	end

	always_ff @(posedge clk) begin
		if (advance && prod_valid) begin
			for (int c = 0; c < num_chan; c++) begin
				out_beat.rgb[c] <= sum[c][prod_w-1:chan_w];
			end
			out_beat.sof <= prod_q.sof;
			out_beat.eol <= prod_q.eol;
		end
	end

endmodule

`default_nettype wire

//--- design/video_blender.sv
`default_nettype none

module video_blender (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  bg_valid,
	output logic                  bg_ready,
	input  blend_pkg::grey_beat_t bg_beat,
	input  logic                  ovl_valid,
	output logic                  ovl_ready,
	input  blend_pkg::ovl_beat_t  ovl_beat,
	input  logic                  ovl_enable,
	output logic                  out_valid,
	input  logic                  out_ready,
	output blend_pkg::rgb_beat_t  out_beat
);
	import blend_pkg::*;

	logic       bg_al_valid;
	logic       bg_al_ready;
	grey_beat_t bg_al_beat;

	logic      ovl_al_valid;
	logic      ovl_al_ready;
	ovl_beat_t ovl_al_beat;

	stream_align #(
		.beat_t(grey_beat_t)
	) bg_align_i (
		.clk      (clk),
		.resetn   (resetn),
		.in_valid (bg_valid),
		.in_ready (bg_ready),
		.in_beat  (bg_beat),
		.out_valid(bg_al_valid),
		.out_ready(bg_al_ready),
		.out_beat (bg_al_beat)
	);

	stream_align #(
		.beat_t(ovl_beat_t)
	) ovl_align_i (
		.clk      (clk),
		.resetn   (resetn),
		.in_valid (ovl_valid),
		.in_ready (ovl_ready),
		.in_beat  (ovl_beat),
		.out_valid(ovl_al_valid),
		.out_ready(ovl_al_ready),
		.out_beat (ovl_al_beat)
	);

	alpha_blend blend_i (
		.clk       (clk),
		.resetn    (resetn),
		.ovl_enable(ovl_enable),
		.bg_valid  (bg_al_valid),
		.bg_ready  (bg_al_ready),
		.bg_beat   (bg_al_beat),
		.ovl_valid (ovl_al_valid),
		.ovl_ready (ovl_al_ready),
		.ovl_beat  (ovl_al_beat),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_beat  (out_beat)
	);

endmodule

`default_nettype wire

//--- tests/video_blender_properties.sv
`default_nettype none

module video_blender_properties (
	input logic                 clk,
	input logic                 resetn,
	input logic                 ovl_enable,
	input logic                 out_valid,
	input logic                 out_ready,
	input blend_pkg::rgb_beat_t out_beat,
	input logic                 join_bg_valid,
	input logic                 join_bg_ready,
	input logic                 join_bg_sof,
	input logic                 join_ovl_ready
);

	logic frame_pass;

	// frame mode as seen by the join.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			frame_pass <= 1'b1;
		end else if (join_bg_valid && join_bg_ready && join_bg_sof) begin
			frame_pass <= !ovl_enable;
		end
	end

	out_stable: assert property (@(posedge clk) disable iff (!resetn)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
		else $error("out_valid or out_beat changed while stalled");

	reset_idle: assert property (@(posedge clk) !resetn |=> !out_valid)
		else $error("out_valid high after a reset cycle");

	pass_no_ovl: assert property (@(posedge clk) disable iff (!resetn)
		frame_pass && !join_bg_sof |-> !join_ovl_ready)
		else $error("overlay ready high in pass mode");

endmodule

bind video_blender video_blender_properties props_i (
	.clk           (clk),
	.resetn        (resetn),
	.ovl_enable    (ovl_enable),
	.out_valid     (out_valid),
	.out_ready     (out_ready),
	.out_beat      (out_beat),
	.join_bg_valid (bg_al_valid),
	.join_bg_ready (bg_al_ready),
	.join_bg_sof   (bg_al_beat.sof),
	.join_ovl_ready(ovl_al_ready)
);

`default_nettype wire

//--- tests/tb_video_blender.sv
`default_nettype none

module tb_video_blender;
	import blend_pkg::*;

	localparam int timeout = 1000;

	logic clk = 1'b0;
	logic resetn;
	logic bg_valid;
	logic bg_ready;
	logic ovl_valid;
	logic ovl_ready;
	logic ovl_enable;
	logic out_valid;
	logic out_ready;
	grey_beat_t bg_beat;
	ovl_beat_t  ovl_beat;
	rgb_beat_t  out_beat;

	logic [31:0] rng_state = 32'h7b2674e5;
	int          errors = 0;
	int          checks = 0;
	int          cycle = 0;
	bit          stall_en = 0;
	bit          pass_chk = 0;
	grey_beat_t  bg_q[$];
	ovl_beat_t   ovl_q[$];
	rgb_beat_t   exp_q[$];

	video_blender dut_i (.*);

	always #5 clk = ~clk;
	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] rand32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// w = a + a[7], result = (o*w + g*(256-w)) >> 8.
	function automatic logic [7:0] blend_chan(logic [7:0] o, logic [7:0] g, logic [7:0] a);
		logic [8:0]  w;
		logic [16:0] s;
		w = {1'b0, a} + {8'd0, a[7]};
		s = o * w + g * (9'd256 - w);
		return s[15:8];
	endfunction

	task automatic abort_timeout(string what);
		$display("timeout: %s", what);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic make_frame(int w, int h, int alpha, bit enable);
		grey_beat_t  g;
		ovl_beat_t   o;
		rgb_beat_t   e;
		logic [31:0] r;
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				r = rand32();
				g.pix = r[7:0];
				g.sof = (x == 0 && y == 0);
				g.eol = (x == w - 1);
				r = rand32();
				o.rgb = r[23:0];
				o.alpha = (alpha < 0) ? r[31:24] : alpha[7:0];
				o.sof = g.sof;
				o.eol = g.eol;
				e.sof = g.sof;
				e.eol = g.eol;
				for (int c = 0; c < 3; c++) begin
					e.rgb[c] = enable ? blend_chan(o.rgb[c], g.pix, o.alpha) : g.pix;
				end
				bg_q.push_back(g);
				if (enable) ovl_q.push_back(o);
				exp_q.push_back(e);
			end
		end
	endtask

	task automatic push_garbage(int nbg, int novl);
		logic [31:0] r;
		for (int i = 0; i < nbg; i++) begin
			r = rand32();
			bg_q.push_back(grey_beat_t'{pix: r[7:0], sof: 1'b0, eol: r[8]});
		end
		for (int i = 0; i < novl; i++) begin
			r = rand32();
			ovl_q.push_back(ovl_beat_t'{rgb: r[23:0], alpha: r[31:24], sof: 1'b0, eol: r[9]});
		end
	endtask

	task automatic send_bg();
		int t;
		while (bg_q.size() > 0) begin
			@(negedge clk);
			bg_beat = bg_q.pop_front();
			bg_valid = 1'b1;
			t = 0;
			while (!bg_ready) begin
				@(negedge clk);
				t++;
				if (t > timeout) abort_timeout("background beat never accepted");
			end
		end
		@(negedge clk);
		bg_valid = 1'b0;
	endtask

	task automatic send_ovl();
		int t;
		while (ovl_q.size() > 0) begin
			@(negedge clk);
			ovl_beat = ovl_q.pop_front();
			ovl_valid = 1'b1;
			t = 0;
			while (!ovl_ready) begin
				@(negedge clk);
				t++;
				if (t > timeout) abort_timeout("overlay beat never accepted");
			end
		end
		@(negedge clk);
		ovl_valid = 1'b0;
	endtask

	task automatic check_beat(rgb_beat_t got);
		rgb_beat_t e;
		e = exp_q.pop_front();
		checks++;
		assert (got == e) else begin
			errors++;
			$display("[ERROR] out_beat got %h exp %h", got, e);
		end
	endtask

	task automatic collect(int n);
		int          got;
		int          t;
		logic [31:0] r;
		got = 0;
		t = 0;
		while (got < n) begin
			@(negedge clk);
			r = rand32();
			out_ready = stall_en ? (r[1:0] != 2'b00) : 1'b1;
			assert (!(pass_chk && dut_i.blend_i.ovl_ready)) else begin
				errors++;
				$display("overlay ready went high during a pass mode frame");
			end
			if (out_valid && out_ready) begin
				check_beat(out_beat);
				got++;
				t = 0;
			end else begin
				t++;
				if (t > timeout) abort_timeout("expected output beat never arrived");
			end
		end
		@(negedge clk);
		out_ready = 1'b1;
	endtask

	task automatic expect_idle(int n);
		repeat (n) begin
			@(negedge clk);
			checks++;
			assert (!out_valid) else begin
				errors++;
				$display("unexpected output beat appeared");
			end
		end
	endtask

	task automatic run_frame();
		int n;
		n = exp_q.size();
		fork
			send_bg();
			send_ovl();
			collect(n);
		join
		expect_idle(10);
	endtask

	task automatic test_reset();
		checks++;
		assert (!out_valid) else begin
			errors++;
			$display("[ERROR] out_valid got %h exp %h", out_valid, 1'b0);
		end
		push_garbage(4, 4);
		fork
			send_bg();
			send_ovl();
		join
		expect_idle(10);
	endtask

	task automatic test_flags_align();
		ovl_enable = 1'b1;
		push_garbage(3, 5);
		make_frame(4, 3, -1, 1);
		run_frame();
	endtask

	task automatic test_extremes();
		make_frame(3, 2, 255, 1);
		run_frame();
		make_frame(3, 2, 0, 1);
		run_frame();
	endtask

	task automatic test_random_stall();
		stall_en = 1;
		make_frame(8, 4, -1, 1);
		run_frame();
		stall_en = 0;
	endtask

	task automatic test_latency();
		int acc;
		int t;
		make_frame(1, 1, -1, 1);
		@(negedge clk);
		bg_beat = bg_q.pop_front();
		ovl_beat = ovl_q.pop_front();
		bg_valid = 1'b1;
		ovl_valid = 1'b1;
		acc = cycle + 1;
		@(negedge clk);
		bg_valid = 1'b0;
		ovl_valid = 1'b0;
		t = 0;
		while (!out_valid) begin
			@(negedge clk);
			t++;
			if (t > timeout) abort_timeout("latency beat never arrived");
		end
		checks++;
		assert (cycle - acc == 2) else begin // aligner edge, join edge, output edge.
			errors++;
			$display("[ERROR] latency got %h exp %h", cycle - acc, 2);
		end
		check_beat(out_beat);
		expect_idle(5);
	endtask

	task automatic test_pass();
		ovl_enable = 1'b0;
		pass_chk = 1;
		make_frame(5, 2, -1, 0);
		run_frame();
		pass_chk = 0;
	endtask

	initial begin
		resetn = 1'b0;
		bg_valid = 1'b0;
		ovl_valid = 1'b0;
		bg_beat = '0;
		ovl_beat = '0;
		ovl_enable = 1'b1;
		out_ready = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		test_reset();
		test_flags_align();
		test_extremes();
		test_random_stall();
		test_latency();
		test_pass();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- video_blender.f
design/blend_pkg.sv
design/stream_align.sv
design/alpha_blend.sv
design/video_blender.sv
tests/video_blender_properties.sv
tests/tb_video_blender.sv

//--- Makefile
TOP = tb_video_blender

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f video_blender.f \
		-o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '>>> PASS'

clean:
	rm -rf obj_dir
